/* hw/axi_bus_pkg.sv */
package axi_bus_pkg;

    // ========================================
    // bus widths
    // ========================================
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // config port.
    localparam int CFG_ADDR_WIDTH = 2;
    localparam int CNT_WIDTH      = 16;

    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_PRIO    = 2'd0;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_IFU_CNT = 2'd1;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_LSU_CNT = 2'd2;

    // ========================================
    // encodings
    // ========================================
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        GRANT_IDLE = 2'd0,
        GRANT_IFU  = 2'd1,
        GRANT_LSU  = 2'd2
    } grant_e;

    // ========================================
    // channel bundles
    // ========================================
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] aw_addr;
        logic                  aw_valid;
        logic [DATA_WIDTH-1:0] w_data;
        logic [STRB_WIDTH-1:0] w_strb;
        logic                  w_valid;
        logic                  b_ready;
        logic [ADDR_WIDTH-1:0] ar_addr;
        logic                  ar_valid;
        logic                  r_ready;
    } axi_req_t;

    typedef struct packed {
        logic                  aw_ready;
        logic                  w_ready;
        axi_resp_e             b_resp;
        logic                  b_valid;
        logic                  ar_ready;
        logic [DATA_WIDTH-1:0] r_data;
        axi_resp_e             r_resp;
        logic                  r_valid;
    } axi_rsp_t;

endpackage

/* hw/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,

    // masters.
    input  axi_bus_pkg::axi_req_t ifu_req,
    output axi_bus_pkg::axi_rsp_t ifu_rsp,
    input  axi_bus_pkg::axi_req_t lsu_req,
    output axi_bus_pkg::axi_rsp_t lsu_rsp,

    // single slave.
    output axi_bus_pkg::axi_req_t slv_req,
    input  axi_bus_pkg::axi_rsp_t slv_rsp,

    input  logic                  prio_ifu,
    output logic                  ifu_done,
    output logic                  lsu_done
);
    import axi_bus_pkg::*;

    grant_e grant_q;
    grant_e grant_d;
    logic   ifu_busy;
    logic   lsu_busy;
    logic   rsp_done;

    // a master wants the bus while any address or data channel is valid.
    assign ifu_busy = ifu_req.ar_valid | ifu_req.aw_valid | ifu_req.w_valid;
    assign lsu_busy = lsu_req.ar_valid | lsu_req.aw_valid | lsu_req.w_valid;

    // response handshake at the slave ends the transaction.
    assign rsp_done = (slv_rsp.r_valid & slv_req.r_ready)
                    | (slv_rsp.b_valid & slv_req.b_ready);

    // ========================================
    // grant FSM
    // ========================================
    always_comb begin
        grant_d = grant_q;
        unique case (grant_q)
            GRANT_IDLE: begin
                if (ifu_busy && (prio_ifu || !lsu_busy)) begin
                    grant_d = GRANT_IFU;
                end else if (lsu_busy) begin
                    grant_d = GRANT_LSU;
                end
            end
            GRANT_IFU: begin
                if (rsp_done) begin
                    if (lsu_busy) begin
                        grant_d = GRANT_LSU;    // alternate.
                    end else if (!ifu_busy) begin
                        grant_d = GRANT_IDLE;
                    end
                end
            end
            GRANT_LSU: begin
                if (rsp_done) begin
                    if (ifu_busy) begin
                        grant_d = GRANT_IFU;
                    end else if (!lsu_busy) begin
                        grant_d = GRANT_IDLE;
                    end
                end
            end
            default: begin
                grant_d = GRANT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_q <= GRANT_IDLE;
        end else begin
            grant_q <= grant_d;
        end
    end

    // ========================================
    // channel mux
    // ========================================
    always_comb begin
        unique case (grant_q)
            GRANT_IFU: slv_req = ifu_req;
            GRANT_LSU: slv_req = lsu_req;
            default:   slv_req = '0;    // nothing reaches the slave when idle.
        endcase
    end

    // loser sees every ready and valid low.
    always_comb begin
        ifu_rsp = '0;
        lsu_rsp = '0;
        if (grant_q == GRANT_IFU) begin
            ifu_rsp = slv_rsp;
        end
        if (grant_q == GRANT_LSU) begin
            lsu_rsp = slv_rsp;
        end
    end

    assign ifu_done = rsp_done & (grant_q == GRANT_IFU);
    assign lsu_done = rsp_done & (grant_q == GRANT_LSU);

endmodule

/* hw/arb_config_regs.sv */
`timescale 1ns/10ps

module arb_config_regs (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   cfg_we,
    input  logic [axi_bus_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [axi_bus_pkg::DATA_WIDTH-1:0]     cfg_wdata,
    output logic [axi_bus_pkg::DATA_WIDTH-1:0]     cfg_rdata,
    input  logic                                   ifu_done,
    input  logic                                   lsu_done,
    output logic                                   prio_ifu
);
    import axi_bus_pkg::*;

    logic [CNT_WIDTH-1:0] ifu_cnt_q;
    logic [CNT_WIDTH-1:0] lsu_cnt_q;

    // the LSU wins ties while this is 0.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio_ifu <= 1'b0;
        end else if (cfg_we && cfg_addr == CFG_PRIO) begin
            prio_ifu <= cfg_wdata[0];
        end
    end

    // ========================================
    // completion counters
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ifu_cnt_q <= '0;
            lsu_cnt_q <= '0;
        end else begin
            if (cfg_we && cfg_addr == CFG_IFU_CNT) begin
                ifu_cnt_q <= '0;                    // clear beats a count.
            end else if (ifu_done) begin
                ifu_cnt_q <= ifu_cnt_q + 1'b1;
            end
            if (cfg_we && cfg_addr == CFG_LSU_CNT) begin
                lsu_cnt_q <= '0;
            end else if (lsu_done) begin
                lsu_cnt_q <= lsu_cnt_q + 1'b1;
            end
        end
    end

    // combinational read port.
    always_comb begin
        unique case (cfg_addr)
            CFG_PRIO:    cfg_rdata = DATA_WIDTH'(prio_ifu);
            CFG_IFU_CNT: cfg_rdata = DATA_WIDTH'(ifu_cnt_q);
            CFG_LSU_CNT: cfg_rdata = DATA_WIDTH'(lsu_cnt_q);
            default:     cfg_rdata = '0;
        endcase
    end

endmodule

/* hw/axi_lite_sram.sv */
`timescale 1ns/10ps

module axi_lite_sram #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  axi_bus_pkg::axi_req_t req,
    output axi_bus_pkg::axi_rsp_t rsp
);
    import axi_bus_pkg::*;

    localparam int WORD_WIDTH = ADDR_WIDTH - 2;
    localparam int IDX_WIDTH  = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam logic [WORD_WIDTH-1:0] DEPTH_WORDS = WORD_WIDTH'(MEM_DEPTH);

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_RD_RSP = 2'd1,
        ST_WR_RSP = 2'd2
    } sram_state_e;

    sram_state_e           state_q;
    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
    logic [DATA_WIDTH-1:0] rdata_q;
    axi_resp_e             rresp_q;
    axi_resp_e             bresp_q;

    logic [WORD_WIDTH-1:0] ar_word;
    logic [WORD_WIDTH-1:0] aw_word;
    logic [IDX_WIDTH-1:0]  ar_idx;
    logic [IDX_WIDTH-1:0]  aw_idx;
    logic                  ar_ok;
    logic                  aw_ok;
    logic                  rd_fire;
    logic                  wr_fire;

    // low two bits dropped for word alignment.
    assign ar_word = req.ar_addr[ADDR_WIDTH-1:2];
    assign aw_word = req.aw_addr[ADDR_WIDTH-1:2];
    assign ar_idx  = ar_word[IDX_WIDTH-1:0];
    assign aw_idx  = aw_word[IDX_WIDTH-1:0];
    assign ar_ok   = ar_word < DEPTH_WORDS;
    assign aw_ok   = aw_word < DEPTH_WORDS;

    // read wins if both sides show up together.
    assign rd_fire = (state_q == ST_IDLE) & req.ar_valid;
    assign wr_fire = (state_q == ST_IDLE) & req.aw_valid & req.w_valid & ~req.ar_valid;

    // ========================================
    // response FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            unique case (state_q)
                ST_IDLE: begin
                    if (rd_fire) begin
                        state_q <= ST_RD_RSP;
                    end else if (wr_fire) begin
                        state_q <= ST_WR_RSP;
                    end
                end
                ST_RD_RSP: begin
                    if (req.r_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_WR_RSP: begin
                    if (req.b_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // storage and response payload
    // ========================================
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_q <= ar_ok ? mem[ar_idx] : '0;
            rresp_q <= ar_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_fire) begin
            bresp_q <= aw_ok ? RESP_OKAY : RESP_SLVERR;
            if (aw_ok) begin
                for (int i = 0; i < STRB_WIDTH; i++) begin
                    if (req.w_strb[i]) begin
                        mem[aw_idx][8*i +: 8] <= req.w_data[8*i +: 8];   // byte merge.
                    end
                end
            end
        end
    end

    always_comb begin
        rsp          = '0;
        rsp.ar_ready = (state_q == ST_IDLE);
        rsp.aw_ready = wr_fire;
        rsp.w_ready  = wr_fire;
        rsp.r_valid  = (state_q == ST_RD_RSP);
        rsp.r_data   = rdata_q;
        rsp.r_resp   = rresp_q;
        rsp.b_valid  = (state_q == ST_WR_RSP);
        rsp.b_resp   = bresp_q;
    end

endmodule

/* hw/mem_subsystem_top.sv */
`timescale 1ns/10ps

module mem_subsystem_top #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                                   clk,
    input  logic                                   rst_n,

    input  axi_bus_pkg::axi_req_t                  ifu_req,
    output axi_bus_pkg::axi_rsp_t                  ifu_rsp,
    input  axi_bus_pkg::axi_req_t                  lsu_req,
    output axi_bus_pkg::axi_rsp_t                  lsu_rsp,

    // config access.
    input  logic                                   cfg_we,
    input  logic [axi_bus_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [axi_bus_pkg::DATA_WIDTH-1:0]     cfg_wdata,
    output logic [axi_bus_pkg::DATA_WIDTH-1:0]     cfg_rdata
);
    import axi_bus_pkg::*;

    axi_req_t slv_req;
    axi_rsp_t slv_rsp;
    logic     prio_ifu;
    logic     ifu_done;
    logic     lsu_done;

    bus_arbiter u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .ifu_req  (ifu_req),
        .ifu_rsp  (ifu_rsp),
        .lsu_req  (lsu_req),
        .lsu_rsp  (lsu_rsp),
        .slv_req  (slv_req),
        .slv_rsp  (slv_rsp),
        .prio_ifu (prio_ifu),
        .ifu_done (ifu_done),
        .lsu_done (lsu_done)
    );

    arb_config_regs u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .ifu_done  (ifu_done),
        .lsu_done  (lsu_done),
        .prio_ifu  (prio_ifu)
    );

    axi_lite_sram #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (slv_req),
        .rsp   (slv_rsp)
    );

endmodule

/* verification/bus_arbiter_checker.sv */
`timescale 1ns/10ps

module bus_arbiter_checker (
    input logic                  clk,
    input logic                  rst_n,
    input axi_bus_pkg::grant_e   grant_q,
    input axi_bus_pkg::axi_req_t slv_req,
    input axi_bus_pkg::axi_rsp_t slv_rsp,
    input axi_bus_pkg::axi_rsp_t ifu_rsp,
    input axi_bus_pkg::axi_rsp_t lsu_rsp
);
    import axi_bus_pkg::*;

    logic ifu_rsp_valid;
    logic lsu_rsp_valid;
    logic rsp_stalled;

    assign ifu_rsp_valid = ifu_rsp.r_valid | ifu_rsp.b_valid;
    assign lsu_rsp_valid = lsu_rsp.r_valid | lsu_rsp.b_valid;

    // response up at the slave but not taken yet.
    assign rsp_stalled = (slv_rsp.r_valid & ~slv_req.r_ready)
                       | (slv_rsp.b_valid & ~slv_req.b_ready);

    one_rsp_owner: assert property (@(posedge clk) disable iff (!rst_n)
        !(ifu_rsp_valid && lsu_rsp_valid))
        else $error("response valid reached both masters");

    grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_stalled |=> $stable(grant_q))
        else $error("grant changed while a response was pending");

    ifu_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (grant_q == GRANT_LSU) |-> !ifu_rsp_valid)
        else $error("ifu saw a response valid while the lsu held the grant");

    lsu_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (grant_q == GRANT_IFU) |-> !lsu_rsp_valid)
        else $error("lsu saw a response valid while the ifu held the grant");

endmodule

bind bus_arbiter bus_arbiter_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .grant_q (grant_q),
    .slv_req (slv_req),
    .slv_rsp (slv_rsp),
    .ifu_rsp (ifu_rsp),
    .lsu_rsp (lsu_rsp)
);

/* verification/mem_subsystem_tb.sv */
`timescale 1ns/10ps

module mem_subsystem_tb;
    import axi_bus_pkg::*;

    localparam int MEM_DEPTH    = 256;
    localparam int TIMEOUT      = 50;
    localparam int STALL_CYCLES = 6;
    localparam int M_IFU        = 0;
    localparam int M_LSU        = 1;
    localparam logic [31:0] OOR_ADDR = 32'(4 * (MEM_DEPTH + 5));   // aliases word 5.

    typedef enum {OP_WRITE, OP_READ, OP_PAIR, OP_STALL} op_e;
    typedef enum {FLD_AR_READY, FLD_AW_READY, FLD_R_VALID, FLD_B_VALID} flag_e;

    typedef struct {
        string       name;
        int          master;
        op_e         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        bit          prio;
    } entry_t;

    logic                      clk;
    logic                      rst_n;
    axi_req_t                  ifu_req;
    axi_req_t                  lsu_req;
    axi_rsp_t                  ifu_rsp;
    axi_rsp_t                  lsu_rsp;
    logic                      cfg_we;
    logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
    logic [DATA_WIDTH-1:0]     cfg_wdata;
    logic [DATA_WIDTH-1:0]     cfg_rdata;

    logic [DATA_WIDTH-1:0] ref_mem [MEM_DEPTH];
    logic [15:0]           lfsr_q;
    int                    cycle_cnt;
    int                    done_cnt [2];
    entry_t                table_q [$];

    mem_subsystem_top #(.MEM_DEPTH(MEM_DEPTH)) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .ifu_req   (ifu_req),
        .ifu_rsp   (ifu_rsp),
        .lsu_req   (lsu_req),
        .lsu_rsp   (lsu_rsp),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ========================================
    // helpers
    // ========================================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // one step per bit over x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic bit in_range(input logic [31:0] addr);
        return (addr >> 2) < MEM_DEPTH;
    endfunction

    function automatic axi_rsp_t rsp_of(input int m);
        return (m == M_IFU) ? ifu_rsp : lsu_rsp;
    endfunction

    function automatic logic rsp_flag(input int m, input flag_e f);
        axi_rsp_t s;
        s = rsp_of(m);
        case (f)
            FLD_AR_READY: return s.ar_ready;
            FLD_AW_READY: return s.aw_ready & s.w_ready;
            FLD_R_VALID:  return s.r_valid;
            default:      return s.b_valid;
        endcase
    endfunction

    function automatic void add_entry(input string name, input int master, input op_e op,
                                      input logic [31:0] addr, input logic [3:0] strb,
                                      input bit prio);
        entry_t e;
        e.name   = name;
        e.master = master;
        e.op     = op;
        e.addr   = addr;
        e.strb   = strb;
        e.prio   = prio;
        e.data   = (op == OP_WRITE) ? rand_bits(DATA_WIDTH) : '0;
        table_q.push_back(e);
    endfunction

    task automatic drive_req(input int m, input axi_req_t r);
        if (m == M_IFU) begin
            ifu_req <= r;
        end else begin
            lsu_req <= r;
        end
    endtask

    task automatic wait_flag(input int m, input flag_e f, input string name, output int cyc);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rsp_flag(m, f) && n < TIMEOUT);
        if (!rsp_flag(m, f)) begin
            abort_run($sformatf("timeout waiting for %s in test %s", f.name(), name));
        end else begin
            cyc = cycle_cnt;
        end
    endtask

    // ========================================
    // bus and config access
    // ========================================
    task automatic do_read(input int m, input logic [31:0] addr, input string name,
                           output logic [31:0] data, output axi_resp_e resp,
                           output int ar_cyc, output int r_cyc);
        axi_req_t r;
        axi_rsp_t s;
        r          = '0;
        r.ar_addr  = addr;
        r.ar_valid = 1'b1;
        r.r_ready  = 1'b1;
        @(posedge clk);
        drive_req(m, r);
        wait_flag(m, FLD_AR_READY, name, ar_cyc);
        @(posedge clk);
        r.ar_valid = 1'b0;
        drive_req(m, r);
        wait_flag(m, FLD_R_VALID, name, r_cyc);
        s    = rsp_of(m);
        data = s.r_data;
        resp = s.r_resp;
        @(posedge clk);
        drive_req(m, '0);
        done_cnt[m]++;
    endtask

    task automatic do_write(input int m, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input string name,
                            output axi_resp_e resp);
        axi_req_t r;
        axi_rsp_t s;
        int       cyc;
        r          = '0;
        r.aw_addr  = addr;
        r.aw_valid = 1'b1;
        r.w_data   = data;
        r.w_strb   = strb;
        r.w_valid  = 1'b1;
        r.b_ready  = 1'b1;
        @(posedge clk);
        drive_req(m, r);
        wait_flag(m, FLD_AW_READY, name, cyc);
        @(posedge clk);
        r.aw_valid = 1'b0;
        r.w_valid  = 1'b0;
        drive_req(m, r);
        wait_flag(m, FLD_B_VALID, name, cyc);
        s    = rsp_of(m);
        resp = s.b_resp;
        @(posedge clk);
        drive_req(m, '0);
        done_cnt[m]++;
    endtask

    task automatic expect_read(input string name, input logic [31:0] addr,
                               input logic [31:0] data, input axi_resp_e resp);
        check_val({name, " rdata"}, in_range(addr) ? ref_mem[addr >> 2] : '0, data);
        check_val({name, " rresp"}, in_range(addr) ? RESP_OKAY : RESP_SLVERR, resp);
    endtask

    task automatic cfg_write(input logic [CFG_ADDR_WIDTH-1:0] a, input logic [31:0] d);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= a;
        cfg_wdata <= d;
        @(posedge clk);
        cfg_we    <= 1'b0;
    endtask

    task automatic cfg_check(input logic [CFG_ADDR_WIDTH-1:0] a, input logic [31:0] exp,
                             input string name);
        @(posedge clk);
        cfg_addr <= a;
        @(negedge clk);
        check_val(name, exp, cfg_rdata);
    endtask

    // granted master holds r_ready low while the other one asks.
    task automatic run_stall(input entry_t e);
        axi_req_t    r;
        axi_rsp_t    s;
        logic [31:0] o_data;
        axi_resp_e   o_resp;
        int          cyc;
        int          o_ar;
        int          o_r;
        int          other;
        other      = 1 - e.master;
        r          = '0;
        r.ar_addr  = e.addr;
        r.ar_valid = 1'b1;
        @(posedge clk);
        drive_req(e.master, r);
        wait_flag(e.master, FLD_AR_READY, e.name, cyc);
        @(posedge clk);
        r.ar_valid = 1'b0;
        drive_req(e.master, r);
        wait_flag(e.master, FLD_R_VALID, e.name, cyc);
        fork
            begin
                repeat (STALL_CYCLES) begin
                    @(negedge clk);
                    s = rsp_of(e.master);
                    check_val({e.name, " held r_valid"}, 1, s.r_valid);
                    s = rsp_of(other);
                    check_val({e.name, " other ar_ready"}, 0, s.ar_ready);
                end
                @(posedge clk);
                r.r_ready = 1'b1;
                drive_req(e.master, r);
                @(negedge clk);
                s = rsp_of(e.master);
                expect_read(e.name, e.addr, s.r_data, s.r_resp);
                @(posedge clk);
                drive_req(e.master, '0);
                done_cnt[e.master]++;
            end
            do_read(other, e.addr, {e.name, " other"}, o_data, o_resp, o_ar, o_r);
        join
        expect_read({e.name, " other"}, e.addr, o_data, o_resp);
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] d [2];
        axi_resp_e   rs [2];
        int          ar_cyc [2];
        int          r_cyc [2];
        int          win;
        case (e.op)
            OP_WRITE: begin
                do_write(e.master, e.addr, e.data, e.strb, e.name, rs[0]);
                check_val({e.name, " bresp"}, in_range(e.addr) ? RESP_OKAY : RESP_SLVERR,
                          rs[0]);
                for (int i = 0; i < STRB_WIDTH; i++) begin
                    if (in_range(e.addr) && e.strb[i]) begin
                        ref_mem[e.addr >> 2][8*i +: 8] = e.data[8*i +: 8];
                    end
                end
            end
            OP_READ: begin
                do_read(e.master, e.addr, e.name, d[0], rs[0], ar_cyc[0], r_cyc[0]);
                expect_read(e.name, e.addr, d[0], rs[0]);
            end
            OP_PAIR: begin
                cfg_write(CFG_PRIO, 32'(e.prio));
                cfg_check(CFG_PRIO, 32'(e.prio), {e.name, " prio"});
                win = e.prio ? M_IFU : M_LSU;
                fork
                    do_read(M_IFU, e.addr, e.name, d[0], rs[0], ar_cyc[0], r_cyc[0]);
                    do_read(M_LSU, e.addr, e.name, d[1], rs[1], ar_cyc[1], r_cyc[1]);
                join
                assert (r_cyc[win] < ar_cyc[1 - win]) else
                    abort_run($sformatf("wrong arbitration order in test %s", e.name));
                expect_read({e.name, " ifu"}, e.addr, d[0], rs[0]);
                expect_read({e.name, " lsu"}, e.addr, d[1], rs[1]);
            end
            default: begin
                run_stall(e);
            end
        endcase
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        ifu_req   = '0;
        lsu_req   = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        cycle_cnt = 0;
        done_cnt  = '{0, 0};
        lfsr_q    = 16'd52818;

        add_entry("ifu_wr_full0", M_IFU, OP_WRITE, 32'h000, 4'hf, 1'b0);
        add_entry("ifu_wr_full1", M_IFU, OP_WRITE, 32'h004, 4'hf, 1'b0);
        add_entry("lsu_wr_full5", M_LSU, OP_WRITE, 32'h014, 4'hf, 1'b0);
        add_entry("lsu_wr_full9", M_LSU, OP_WRITE, 32'h024, 4'hf, 1'b0);
        add_entry("ifu_wr_part0", M_IFU, OP_WRITE, 32'h000, 4'h3, 1'b0);
        add_entry("lsu_wr_part5", M_LSU, OP_WRITE, 32'h014, 4'ha, 1'b0);
        add_entry("ifu_wr_byte9", M_IFU, OP_WRITE, 32'h024, 4'h4, 1'b0);
        add_entry("ifu_rd0", M_IFU, OP_READ, 32'h000, 4'h0, 1'b0);
        add_entry("lsu_rd1", M_LSU, OP_READ, 32'h004, 4'h0, 1'b0);
        add_entry("ifu_rd5", M_IFU, OP_READ, 32'h014, 4'h0, 1'b0);
        add_entry("lsu_rd9", M_LSU, OP_READ, 32'h024, 4'h0, 1'b0);
        add_entry("lsu_wr_oor", M_LSU, OP_WRITE, OOR_ADDR, 4'hf, 1'b0);
        add_entry("ifu_rd_oor", M_IFU, OP_READ, OOR_ADDR, 4'h0, 1'b0);
        add_entry("lsu_rd5_after_oor", M_LSU, OP_READ, 32'h014, 4'h0, 1'b0);
        add_entry("pair_lsu_first", M_LSU, OP_PAIR, 32'h004, 4'h0, 1'b0);
        add_entry("pair_ifu_first", M_IFU, OP_PAIR, 32'h024, 4'h0, 1'b1);
        add_entry("stall_lsu", M_LSU, OP_STALL, 32'h000, 4'h0, 1'b0);
        add_entry("stall_ifu", M_IFU, OP_STALL, 32'h014, 4'h0, 1'b0);

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_val("reset ifu_rsp", '0, {ifu_rsp.aw_ready, ifu_rsp.w_ready, ifu_rsp.b_valid,
                                        ifu_rsp.ar_ready, ifu_rsp.r_valid});
        check_val("reset lsu_rsp", '0, {lsu_rsp.aw_ready, lsu_rsp.w_ready, lsu_rsp.b_valid,
                                        lsu_rsp.ar_ready, lsu_rsp.r_valid});
        cfg_check(CFG_PRIO, 0, "reset prio");
        cfg_check(CFG_IFU_CNT, 0, "reset ifu_cnt");
        cfg_check(CFG_LSU_CNT, 0, "reset lsu_cnt");

        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end

        // check the counters and clear them one at a time.
        cfg_check(CFG_IFU_CNT, done_cnt[M_IFU], "ifu_cnt");
        cfg_check(CFG_LSU_CNT, done_cnt[M_LSU], "lsu_cnt");
        cfg_write(CFG_IFU_CNT, 0);
        cfg_check(CFG_IFU_CNT, 0, "ifu_cnt cleared");
        cfg_check(CFG_LSU_CNT, done_cnt[M_LSU], "lsu_cnt kept");
        cfg_write(CFG_LSU_CNT, 0);
        cfg_check(CFG_LSU_CNT, 0, "lsu_cnt cleared");
        cfg_check(CFG_IFU_CNT, 0, "ifu_cnt still clear");

        $display(">>> PASS");
        $finish;
    end

endmodule

/* filelist.f */
hw/axi_bus_pkg.sv
hw/bus_arbiter.sv
hw/arb_config_regs.sv
hw/axi_lite_sram.sv
hw/mem_subsystem_top.sv
verification/bus_arbiter_checker.sv
verification/mem_subsystem_tb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - hw/axi_bus_pkg.sv
      - hw/bus_arbiter.sv
      - hw/arb_config_regs.sv
      - hw/axi_lite_sram.sv
      - hw/mem_subsystem_top.sv
  - target: test
    files:
      - verification/bus_arbiter_checker.sv
      - verification/mem_subsystem_tb.sv
